// ==== hdl/core_types_pkg.sv ====
// core types for the reg-immediate ALU issue slice
// widths, the I-type opcode encoding and the structs passed between blocks

package core_types_pkg;

    // ------------------------------------------------------------------------
    // widths

    localparam int PR_COUNT = 64;
    localparam int LOG_PR_COUNT = 6;
    localparam int PRF_BANK_COUNT = 4;
    localparam int LOG_PRF_BANK_COUNT = 2;
    localparam int LOG_ROB_ENTRIES = 6;
    localparam int XLEN = 32;

    // ------------------------------------------------------------------------
    // opcode: {SRAI select, funct3}

    typedef enum logic [3:0] {
        ADDI  = 4'b0000,
        SLLI  = 4'b0001,
        SLTI  = 4'b0010,
        SLTIU = 4'b0011,
        XORI  = 4'b0100,
        SRLI  = 4'b0101,
        ORI   = 4'b0110,
        ANDI  = 4'b0111,
        SRAI  = 4'b1101
    } alu_imm_op_t;

    // ------------------------------------------------------------------------
    // structs

    // one renamed op as it enters the queue
    typedef struct packed {
        alu_imm_op_t                op;
        logic [11:0]                imm12;
        logic [LOG_PR_COUNT-1:0]    A_PR;
        logic                       A_ready;
        logic                       A_is_zero;
        logic [LOG_PR_COUNT-1:0]    dest_PR;
        logic [LOG_ROB_ENTRIES-1:0] ROB_index;
    } iq_enq_t;

    // writeback bus, one lane per PRF bank
    typedef struct packed {
        logic [PRF_BANK_COUNT-1:0]                                      valid;
        logic [PRF_BANK_COUNT-1:0][LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] upper_PR;
        logic [PRF_BANK_COUNT-1:0][XLEN-1:0]                            data;
    } wb_bus_t;

    // issue payload from queue to execute
    typedef struct packed {
        alu_imm_op_t                    op;
        logic [11:0]                    imm12;
        logic                           A_forward;
        logic                           A_is_zero;
        logic [LOG_PRF_BANK_COUNT-1:0]  A_bank;
        logic [LOG_PR_COUNT-1:0]        dest_PR;
        logic [LOG_ROB_ENTRIES-1:0]     ROB_index;
    } issue_t;

    typedef struct packed {
        logic [LOG_PR_COUNT-1:0]    dest_PR;
        logic [LOG_ROB_ENTRIES-1:0] ROB_index;
        logic [XLEN-1:0]            data;
    } alu_result_t;

endpackage

// ==== hdl/pe_lsb.sv ====
// lowest-index-first priority encoder
// one-hot grant of the lowest request plus a mask of every bit at or above it

module pe_lsb #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0] req_vec,
    output logic [WIDTH-1:0] ack_one_hot,
    output logic [WIDTH-1:0] ack_mask
);

    logic seen;

    // running OR from bit 0 up
    always_comb begin
        seen = 1'b0;
        for (int i = 0; i < WIDTH; i++) begin
            seen = seen | req_vec[i];
            ack_mask[i] = seen;
        end
    end

    // grant is where the mask first turns on
    assign ack_one_hot = ack_mask & ~{ack_mask[WIDTH-2:0], 1'b0};

endmodule

// ==== hdl/prf.sv ====
// banked physical register file
// each bank captures its writeback lane, one combinational read port

module prf #(
    parameter int PR_COUNT = 64
) (
    input  logic                                CLK,
    input  logic                                nRST,
    input  core_types_pkg::wb_bus_t             wb,
    input  logic [$clog2(PR_COUNT)-1:0]         rd_PR,
    output logic [core_types_pkg::XLEN-1:0]     rd_data
);

    localparam int BANKS = core_types_pkg::PRF_BANK_COUNT;
    localparam int LOG_BANKS = core_types_pkg::LOG_PRF_BANK_COUNT;
    localparam int ROWS = PR_COUNT / BANKS;
    localparam int LOG_PR = $clog2(PR_COUNT);

    logic [BANKS-1:0][ROWS-1:0][core_types_pkg::XLEN-1:0] regs;

    logic [LOG_BANKS-1:0]           rd_bank;
    logic [LOG_PR-LOG_BANKS-1:0]    rd_row;

    // ------------------------------------------------------------------------
    // write side

    // one write per bank per cycle, no conflicts between lanes
    always_ff @(posedge CLK) begin
        if (!nRST) begin
            regs <= '0;
        end else begin
            for (int b = 0; b < BANKS; b++) begin
                if (wb.valid[b]) begin
                    regs[b][wb.upper_PR[b]] <= wb.data[b];
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // read side

    // low PR bits pick the bank
    assign rd_bank = rd_PR[LOG_BANKS-1:0];
    assign rd_row = rd_PR[LOG_PR-1:LOG_BANKS];

    assign rd_data = regs[rd_bank][rd_row];

endmodule

// ==== hdl/alu_imm_iq.sv ====
// collapsing issue queue for reg-immediate ALU ops
// wakes entries from the writeback bus, issues the oldest ready one,
// and requests its operand from the PRF unless it is forwarded or zero

module alu_imm_iq #(
    parameter int ALU_IMM_IQ_ENTRIES = 12
) (
    input  logic                                        CLK,
    input  logic                                        nRST,
    input  logic                                        enq_valid,
    input  core_types_pkg::iq_enq_t                     enq,
    output logic                                        enq_ready,
    input  core_types_pkg::wb_bus_t                     wb,
    input  logic                                        issue_ready,
    output logic                                        issue_valid,
    output core_types_pkg::issue_t                      issue,
    output logic                                        prf_req_valid,
    output logic [core_types_pkg::LOG_PR_COUNT-1:0]     prf_req_PR
);

    localparam int N = ALU_IMM_IQ_ENTRIES;
    localparam int LOG_PR = core_types_pkg::LOG_PR_COUNT;
    localparam int LOG_BANKS = core_types_pkg::LOG_PRF_BANK_COUNT;

    // entry storage, index 0 is the oldest
    logic [N-1:0]                           valid_q;
    core_types_pkg::iq_enq_t [N-1:0]        entry_q;
    logic [N-1:0]                           valid_next;
    core_types_pkg::iq_enq_t [N-1:0]        entry_next;

    logic [N-1:0] fwd_by_entry;
    logic [N-1:0] ready_by_entry;
    logic [N-1:0] issue_one_hot;
    logic [N-1:0] issue_mask;

    logic [N-1:0] free_mask;
    logic [N-1:0] enq_pe_one_hot;
    logic [N-1:0] enq_one_hot;

    // neighbours one slot up, used when collapsing
    logic [N-1:0]                       valid_above;
    logic [N-1:0]                       fwd_above;
    logic [N-1:0]                       enq_above;
    core_types_pkg::iq_enq_t [N-1:0]    entry_above;

    core_types_pkg::iq_enq_t enq_woken;

    // true when a lane of the bus writes this PR now
    function automatic logic wb_hit(
        input logic [LOG_PR-1:0]        pr,
        input core_types_pkg::wb_bus_t  bus
    );
        logic [LOG_BANKS-1:0] bank;
        bank = pr[LOG_BANKS-1:0];
        return bus.valid[bank] && (bus.upper_PR[bank] == pr[LOG_PR-1:LOG_BANKS]);
    endfunction

    // ------------------------------------------------------------------------
    // wakeup and select

    always_comb begin
        for (int i = 0; i < N; i++) begin
            fwd_by_entry[i] = wb_hit(entry_q[i].A_PR, wb);
            ready_by_entry[i] = issue_ready && valid_q[i]
                && (fwd_by_entry[i] || entry_q[i].A_ready || entry_q[i].A_is_zero);
        end
    end

    pe_lsb #(.WIDTH(N)) issue_pe (
        .req_vec     (ready_by_entry),
        .ack_one_hot (issue_one_hot),
        .ack_mask    (issue_mask)
    );

    assign issue_valid = |ready_by_entry;

    // one-hot mux of the granted entry
    always_comb begin
        issue = '0;
        prf_req_valid = 1'b0;
        prf_req_PR = '0;
        for (int i = 0; i < N; i++) begin
            if (issue_one_hot[i]) begin
                issue.op = entry_q[i].op;
                issue.imm12 = entry_q[i].imm12;
                issue.A_forward = fwd_by_entry[i];
                issue.A_is_zero = entry_q[i].A_is_zero;
                issue.A_bank = entry_q[i].A_PR[LOG_BANKS-1:0];
                issue.dest_PR = entry_q[i].dest_PR;
                issue.ROB_index = entry_q[i].ROB_index;
                prf_req_valid = !fwd_by_entry[i] && !entry_q[i].A_is_zero;
                prf_req_PR = entry_q[i].A_PR;
            end
        end
    end

    // ------------------------------------------------------------------------
    // enqueue into the lowest free slot

    assign free_mask = ~valid_q;
    assign enq_ready = |free_mask;

    pe_lsb #(.WIDTH(N)) enq_pe (
        .req_vec     (free_mask),
        .ack_one_hot (enq_pe_one_hot),
        .ack_mask    ()
    );

    assign enq_one_hot = enq_pe_one_hot & {N{enq_valid}};

    // a writeback in the enqueue cycle still counts
    always_comb begin
        enq_woken = enq;
        enq_woken.A_ready = enq.A_ready | wb_hit(enq.A_PR, wb);
    end

    // ------------------------------------------------------------------------
    // collapse and next state

    assign valid_above = {1'b0, valid_q[N-1:1]};
    assign fwd_above = {1'b0, fwd_by_entry[N-1:1]};
    assign enq_above = {1'b0, enq_one_hot[N-1:1]};
    assign entry_above = {core_types_pkg::iq_enq_t'('0), entry_q[N-1:1]};

    always_comb begin
        for (int i = 0; i < N; i++) begin
            if (issue_mask[i]) begin
                // slot at or above the issue takes from one up
                if (valid_above[i]) begin
                    valid_next[i] = 1'b1;
                    entry_next[i] = entry_above[i];
                    entry_next[i].A_ready = entry_above[i].A_ready | fwd_above[i];
                end else begin
                    valid_next[i] = enq_above[i];
                    entry_next[i] = enq_woken;
                end
            end else if (valid_q[i]) begin
                valid_next[i] = 1'b1;
                entry_next[i] = entry_q[i];
                entry_next[i].A_ready = entry_q[i].A_ready | fwd_by_entry[i];
            end else begin
                valid_next[i] = enq_one_hot[i];
                entry_next[i] = enq_woken;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_next;
        end
    end

    always_ff @(posedge CLK) begin
        entry_q <= entry_next;
    end

endmodule

// ==== hdl/alu_imm_exec.sv ====
// execute stage for reg-immediate ops
// picks the operand at issue, registers it, computes the I-type result

module alu_imm_exec (
    input  logic                                CLK,
    input  logic                                nRST,
    input  logic                                issue_valid,
    input  core_types_pkg::issue_t              issue,
    input  core_types_pkg::wb_bus_t             wb,
    input  logic [core_types_pkg::XLEN-1:0]     prf_rd_data,
    output logic                                result_valid,
    output core_types_pkg::alu_result_t         result
);

    localparam int XLEN = core_types_pkg::XLEN;

    logic [XLEN-1:0] operand;

    // stage registers
    logic                                       valid_q;
    core_types_pkg::alu_imm_op_t                op_q;
    logic [11:0]                                imm12_q;
    logic [XLEN-1:0]                            operand_q;
    logic [core_types_pkg::LOG_PR_COUNT-1:0]    dest_PR_q;
    logic [core_types_pkg::LOG_ROB_ENTRIES-1:0] ROB_index_q;

    logic [XLEN-1:0]    imm_sext;
    logic [4:0]         shamt;
    logic [XLEN-1:0]    alu_out;

    // ------------------------------------------------------------------------
    // operand select in the issue cycle

    always_comb begin
        if (issue.A_is_zero) begin
            operand = '0;
        end else if (issue.A_forward) begin
            operand = wb.data[issue.A_bank];
        end else begin
            operand = prf_rd_data;
        end
    end

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_valid;
        end
    end

    always_ff @(posedge CLK) begin
        op_q <= issue.op;
        imm12_q <= issue.imm12;
        operand_q <= operand;
        dest_PR_q <= issue.dest_PR;
        ROB_index_q <= issue.ROB_index;
    end

    // ------------------------------------------------------------------------
    // ALU

    assign imm_sext = {{(XLEN-12){imm12_q[11]}}, imm12_q};
    assign shamt = imm12_q[4:0];

    always_comb begin
        case (op_q)
            core_types_pkg::ADDI:  alu_out = operand_q + imm_sext;
            core_types_pkg::SLTI:  alu_out = {{(XLEN-1){1'b0}}, $signed(operand_q) < $signed(imm_sext)};
            core_types_pkg::SLTIU: alu_out = {{(XLEN-1){1'b0}}, operand_q < imm_sext};
            core_types_pkg::XORI:  alu_out = operand_q ^ imm_sext;
            core_types_pkg::ORI:   alu_out = operand_q | imm_sext;
            core_types_pkg::ANDI:  alu_out = operand_q & imm_sext;
            core_types_pkg::SLLI:  alu_out = operand_q << shamt;
            core_types_pkg::SRLI:  alu_out = operand_q >> shamt;
            core_types_pkg::SRAI:  alu_out = $unsigned($signed(operand_q) >>> shamt);
            default:               alu_out = '0;
        endcase
    end

    assign result_valid = valid_q;
    assign result.dest_PR = dest_PR_q;
    assign result.ROB_index = ROB_index_q;
    assign result.data = alu_out;

endmodule

// ==== hdl/alu_imm_unit.sv ====
// reg-immediate ALU issue slice
// PRF capture, collapsing issue queue and one-stage execute

module alu_imm_unit #(
    parameter int ALU_IMM_IQ_ENTRIES = 12,
    parameter int PR_COUNT = core_types_pkg::PR_COUNT
) (
    input  logic                            CLK,
    input  logic                            nRST,
    input  logic                            enq_valid,
    input  core_types_pkg::iq_enq_t         enq,
    output logic                            enq_ready,
    input  core_types_pkg::wb_bus_t         wb,
    input  logic                            issue_ready,
    output logic                            result_valid,
    output core_types_pkg::alu_result_t     result
);

    localparam int LOG_PR = core_types_pkg::LOG_PR_COUNT;

    logic                               issue_valid;
    core_types_pkg::issue_t             issue;
    logic                               prf_req_valid;
    logic [LOG_PR-1:0]                  prf_req_PR;
    logic [LOG_PR-1:0]                  prf_rd_PR;
    logic [core_types_pkg::XLEN-1:0]    prf_rd_data;

    // ------------------------------------------------------------------------
    // input side

    prf #(.PR_COUNT(PR_COUNT)) prf_inst (
        .CLK     (CLK),
        .nRST    (nRST),
        .wb      (wb),
        .rd_PR   (prf_rd_PR),
        .rd_data (prf_rd_data)
    );

    // idle read port parks on PR 0
    assign prf_rd_PR = prf_req_PR & {LOG_PR{prf_req_valid}};

    // ------------------------------------------------------------------------
    // queue

    alu_imm_iq #(.ALU_IMM_IQ_ENTRIES(ALU_IMM_IQ_ENTRIES)) iq_inst (
        .CLK           (CLK),
        .nRST          (nRST),
        .enq_valid     (enq_valid),
        .enq           (enq),
        .enq_ready     (enq_ready),
        .wb            (wb),
        .issue_ready   (issue_ready),
        .issue_valid   (issue_valid),
        .issue         (issue),
        .prf_req_valid (prf_req_valid),
        .prf_req_PR    (prf_req_PR)
    );

    // ------------------------------------------------------------------------
    // output side

    alu_imm_exec exec_inst (
        .CLK          (CLK),
        .nRST         (nRST),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .wb           (wb),
        .prf_rd_data  (prf_rd_data),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

// ==== verification/tb_clock.sv ====
// testbench clock and reset
// 20 ns clock, reset held low for the first 10 rising edges

module tb_clock (
    output logic CLK,
    output logic nRST
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // release just after an edge, like every other driven input
    initial begin
        nRST = 1'b0;
        repeat (10) @(posedge CLK);
        #2;
        nRST = 1'b1;
    end

endmodule

// ==== verification/alu_imm_unit_assert.sv ====
// concurrent checks on the reg-immediate ALU slice
// bound into the top level, keeps a count of failed assertions

module alu_imm_unit_assert #(
    parameter int ENTRIES = 12
) (
    input logic                 CLK,
    input logic                 nRST,
    input logic                 enq_ready,
    input logic                 issue_ready,
    input logic                 issue_valid,
    input logic                 result_valid,
    input logic [ENTRIES-1:0]   iq_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;

    a_issue_gated: assert property (@(posedge CLK) disable iff (!nRST)
        issue_valid |-> issue_ready)
        else begin
            failures++;
            $error("issue_valid high while issue_ready is low");
        end

    // execute stage is exactly one register deep
    a_result_latency: assert property (@(posedge CLK) disable iff (!nRST)
        result_valid == $past(issue_valid))
        else begin
            failures++;
            $error("result_valid does not follow issue_valid by one cycle");
        end

    // a full queue must not grow
    a_no_enq_when_full: assert property (@(posedge CLK) disable iff (!nRST)
        !enq_ready |=> $countones(iq_valid) <= $past($countones(iq_valid)))
        else begin
            failures++;
            $error("queue grew while enq_ready was low");
        end

    a_quiet_after_reset: assert property (@(posedge CLK)
        $rose(nRST) |-> !result_valid)
        else begin
            failures++;
            $error("result_valid high in the first cycle after reset");
        end

endmodule

// ==== verification/alu_imm_unit_tb.sv ====
// testbench for the reg-immediate ALU issue slice
// replays enqueue and writeback records, checks results by ROB index
// under random issue_ready back-pressure

module alu_imm_unit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int IQ_ENTRIES = 12;
    localparam int ROB_SLOTS = 2 ** core_types_pkg::LOG_ROB_ENTRIES;

    typedef struct packed {
        logic [7:0]  kind;
        logic [31:0] f0, f1, f2, f3, f4, f5, f6;
    } vec_rec_t;

    logic                           CLK;
    logic                           nRST;
    logic                           enq_valid;
    core_types_pkg::iq_enq_t        enq;
    logic                           enq_ready;
    core_types_pkg::wb_bus_t        wb;
    logic                           issue_ready;
    logic                           result_valid;
    core_types_pkg::alu_result_t    result;

    vec_rec_t                       vec_q [$];
    core_types_pkg::alu_result_t    exp_table [ROB_SLOTS];
    logic                           exp_valid [ROB_SLOTS];
    logic                           seen [ROB_SLOTS];
    int                             expected_count = 0;
    int                             received = 0;
    int                             cycle_count = 0;
    int                             cycle_limit = 100000;
    logic [15:0]                    lfsr;

    tb_clock clock_inst (
        .CLK  (CLK),
        .nRST (nRST)
    );

    alu_imm_unit #(.ALU_IMM_IQ_ENTRIES(IQ_ENTRIES)) alu_imm_unit_inst (
        .CLK          (CLK),
        .nRST         (nRST),
        .enq_valid    (enq_valid),
        .enq          (enq),
        .enq_ready    (enq_ready),
        .wb           (wb),
        .issue_ready  (issue_ready),
        .result_valid (result_valid),
        .result       (result)
    );

    bind alu_imm_unit alu_imm_unit_assert #(.ENTRIES(ALU_IMM_IQ_ENTRIES)) assert_inst (
        .CLK          (CLK),
        .nRST         (nRST),
        .enq_ready    (enq_ready),
        .issue_ready  (issue_ready),
        .issue_valid  (issue_valid),
        .result_valid (result_valid),
        .iq_valid     (iq_inst.valid_q)
    );

    // ------------------------------------------------------------------------
    // helpers

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_result(input string name, input core_types_pkg::alu_result_t expected,
                                input core_types_pkg::alu_result_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_enq_ready(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // starts and ends 2 ns after a rising edge
    task automatic apply_record(input int idx, input vec_rec_t rec);
        int bank;
        case (rec.kind)
            "E": begin
                enq.op = core_types_pkg::alu_imm_op_t'(rec.f0[3:0]);
                enq.imm12 = rec.f1[11:0];
                enq.A_PR = rec.f2[5:0];
                enq.A_ready = rec.f3[0];
                enq.A_is_zero = rec.f4[0];
                enq.dest_PR = rec.f5[5:0];
                enq.ROB_index = rec.f6[5:0];
                enq_valid = 1'b1;
                @(negedge CLK);
                while (!enq_ready) begin
                    @(negedge CLK);
                end
                @(posedge CLK);
                #2;
                enq_valid = 1'b0;
            end
            "W": begin
                bank = rec.f0;
                wb = '0;
                wb.valid[bank] = 1'b1;
                wb.upper_PR[bank] = rec.f1[3:0];
                wb.data[bank] = rec.f2;
                @(posedge CLK);
                #2;
                wb = '0;
            end
            "N": begin
                repeat (rec.f0) begin
                    @(negedge CLK);
                    if (rec.f1 != 2) begin
                        check_enq_ready($sformatf("record %0d enq_ready", idx), rec.f1[0],
                                        enq_ready);
                    end
                    @(posedge CLK);
                    #2;
                end
            end
            default: begin
            end
        endcase
    endtask

    // ------------------------------------------------------------------------
    // issue_ready, low when two LFSR bits are both set

    initial begin
        logic b0;
        logic b1;
        issue_ready = 1'b0;
        lfsr = 16'd77;
        forever begin
            @(posedge CLK);
            #2;
            lfsr = lfsr_step(lfsr);
            b0 = lfsr[0];
            lfsr = lfsr_step(lfsr);
            b1 = lfsr[0];
            issue_ready = !(b0 && b1);
        end
    end

    // ------------------------------------------------------------------------
    // result monitor and timeout

    always @(negedge CLK) begin
        int idx;
        if (alu_imm_unit_inst.assert_inst.failures != 0) begin
            abort_run("a concurrent assertion on the DUT failed");
        end
        if (nRST && result_valid) begin
            idx = result.ROB_index;
            if (!exp_valid[idx]) begin
                abort_run($sformatf("result for ROB index %0d, which no vector expects", idx));
            end else if (seen[idx]) begin
                abort_run($sformatf("ROB index %0d returned a second result", idx));
            end else begin
                check_result($sformatf("rob %0d result", idx), exp_table[idx], result);
                seen[idx] = 1'b1;
                received++;
            end
        end
    end

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            abort_run($sformatf("timeout after %0d cycles, %0d of %0d results arrived",
                                cycle_count, received, expected_count));
        end
    end

    // ------------------------------------------------------------------------
    // main sequence

    initial begin
        vec_rec_t rec;
        int fd;
        int missing;
        string line;
        enq_valid = 1'b0;
        enq = '0;
        wb = '0;
        foreach (exp_valid[i]) begin
            exp_valid[i] = 1'b0;
            seen[i] = 1'b0;
        end
        fd = $fopen("verification/alu_imm_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open verification/alu_imm_vectors.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            rec = '0;
            void'($sscanf(line, "%c %h %h %h %h %h %h %h", rec.kind, rec.f0, rec.f1, rec.f2,
                          rec.f3, rec.f4, rec.f5, rec.f6));
            vec_q.push_back(rec);
            // expected results go straight into the table
            if (rec.kind == "X") begin
                exp_table[rec.f0[5:0]].ROB_index = rec.f0[5:0];
                exp_table[rec.f0[5:0]].dest_PR = rec.f1[5:0];
                exp_table[rec.f0[5:0]].data = rec.f2;
                exp_valid[rec.f0[5:0]] = 1'b1;
                expected_count++;
            end
        end
        $fclose(fd);
        cycle_limit = vec_q.size() * 20 + 200;

        wait (nRST === 1'b1);
        foreach (vec_q[i]) begin
            apply_record(i, vec_q[i]);
        end

        while (received < expected_count) begin
            @(negedge CLK);
        end
        // a few more cycles to catch late duplicates
        repeat (10) @(negedge CLK);

        missing = 0;
        foreach (exp_valid[i]) begin
            if (exp_valid[i] && !seen[i]) begin
                missing++;
            end
        end
        if (missing == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            abort_run($sformatf("%0d expected results never arrived", missing));
        end
    end

endmodule

// ==== flist.f ====
hdl/core_types_pkg.sv
hdl/pe_lsb.sv
hdl/prf.sv
hdl/alu_imm_iq.sv
hdl/alu_imm_exec.sv
hdl/alu_imm_unit.sv
verification/tb_clock.sv
verification/alu_imm_unit_assert.sv
verification/alu_imm_unit_tb.sv

// ==== verification/alu_imm_vectors.txt ====
# E op imm12 A_PR A_ready A_is_zero dest_PR ROB | W bank upper_PR data
# N cycles enq_ready (2 = unchecked) | X ROB dest_PR data | all fields hex
N 2 1
W 1 1 00001234
W 3 0 80000000
E 0 800 05 1 0 20 00
E 6 0f0 03 1 0 21 01
E 0 7ff 00 0 1 22 02
E 3 800 11 0 0 23 03
W 1 4 0000ffff
N 0e 2
E 0 fff 1a 0 0 30 10
E 2 fff 1a 0 0 31 11
E 3 7ff 1a 0 0 32 12
E 4 800 1a 0 0 33 13
E 6 0f0 1a 0 0 34 14
E 7 00c 1a 0 0 35 15
E 1 004 1a 0 0 36 16
E 5 004 1a 0 0 37 17
E d 404 1a 0 0 38 18
E d 41f 1a 0 0 39 19
E 2 800 1a 0 0 3a 1a
E 0 008 1a 0 0 3b 1b
N 2 0
W 2 6 f0000008
E 0 001 07 0 0 3c 1c
W 3 1 7fffffff
X 00 20 00000a34
X 01 21 800000f0
X 02 22 000007ff
X 03 23 00000001
X 10 30 f0000007
X 11 31 00000001
X 12 32 00000000
X 13 33 0ffff808
X 14 34 f00000f8
X 15 35 00000008
X 16 36 00000080
X 17 37 0f000000
X 18 38 ff000000
X 19 39 ffffffff
X 1a 3a 00000001
X 1b 3b f0000010
X 1c 3c 80000000
